/* hdl/report_checksum_appender.sv */
// consumer that forwards the report bytes and appends a modulo-256 checksum as the last byte
`timescale 1ns/100ps

module report_checksum_appender (
    input  logic          clk,
    input  logic          rst,
    stat_report_if.sink   up,
    stat_report_if.source dn
);

    stat_pkg::app_state_e state;

    logic [7:0] sum;
    logic [7:0] out_data;
    logic       out_last;
    logic       out_valid;
    logic       out_free;
    logic       up_take;

    assign out_free = !out_valid || dn.tready;
    // upstream is stalled for the whole checksum phase
    assign up.tready = (state == stat_pkg::PASS) && out_free;
    assign up_take = up.tvalid && up.tready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stat_pkg::PASS;
            sum <= '0;
            out_valid <= 1'b0;
        end else begin
            case (state)
                stat_pkg::PASS: begin
                    if (up_take) begin
                        out_valid <= 1'b1;
                        sum <= sum + up.tdata;
                        if (up.tlast) begin
                            state <= stat_pkg::CHECKSUM;
                        end
                    end else if (dn.tready) begin
                        out_valid <= 1'b0;
                    end
                end
                stat_pkg::CHECKSUM: begin
                    if (out_valid && out_last && dn.tready) begin
                        // checksum accepted downstream
                        out_valid <= 1'b0;
                        sum <= '0;
                        state <= stat_pkg::PASS;
                    end else if (out_free) begin
                        out_valid <= 1'b1;
                    end
                end
                default: state <= stat_pkg::PASS;
            endcase
        end
    end

    // output byte register, end mark only on the checksum
    always_ff @(posedge clk) begin
        if (state == stat_pkg::PASS) begin
            if (up_take) begin
                out_data <= up.tdata;
                out_last <= 1'b0;
            end
        end else if (out_free && !(out_valid && out_last)) begin
            out_data <= sum;
            out_last <= 1'b1;
        end
    end

    assign dn.tdata = out_data;
    assign dn.tlast = out_last;
    assign dn.tvalid = out_valid;

endmodule

/* hdl/report_skid_buffer.sv */
// two-entry skid buffer with a registered upstream ready for the report byte stream
`timescale 1ns/100ps

module report_skid_buffer (
    input  logic          clk,
    input  logic          rst,
    stat_report_if.sink   up,
    stat_report_if.source dn
);

    logic       up_ready_reg;
    logic       up_ready_next;

    // output entry and spill entry
    logic [7:0] out_data;
    logic       out_last;
    logic       out_valid;
    logic       out_valid_next;
    logic [7:0] tmp_data;
    logic       tmp_last;
    logic       tmp_valid;
    logic       tmp_valid_next;

    logic       load_out_from_up;
    logic       load_tmp_from_up;
    logic       load_out_from_tmp;

    // ready next cycle unless the spill entry could fill this cycle
    assign up_ready_next = dn.tready || (!tmp_valid && (!out_valid || !up.tvalid));

    always_comb begin
        out_valid_next = out_valid;
        tmp_valid_next = tmp_valid;
        load_out_from_up = 1'b0;
        load_tmp_from_up = 1'b0;
        load_out_from_tmp = 1'b0;
        if (up_ready_reg) begin
            if (dn.tready || !out_valid) begin
                out_valid_next = up.tvalid;
                load_out_from_up = 1'b1;
            end else begin
                tmp_valid_next = up.tvalid;
                load_tmp_from_up = 1'b1;
            end
        end else if (dn.tready) begin
            // drain spill entry into the output
            out_valid_next = tmp_valid;
            tmp_valid_next = 1'b0;
            load_out_from_tmp = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            up_ready_reg <= 1'b0;
            out_valid <= 1'b0;
            tmp_valid <= 1'b0;
        end else begin
            up_ready_reg <= up_ready_next;
            out_valid <= out_valid_next;
            tmp_valid <= tmp_valid_next;
        end
    end

    always_ff @(posedge clk) begin
        if (load_out_from_up) begin
            out_data <= up.tdata;
            out_last <= up.tlast;
        end else if (load_out_from_tmp) begin
            out_data <= tmp_data;
            out_last <= tmp_last;
        end
        if (load_tmp_from_up) begin
            tmp_data <= up.tdata;
            tmp_last <= up.tlast;
        end
    end

    assign up.tready = up_ready_reg;
    assign dn.tdata = out_data;
    assign dn.tlast = out_last;
    assign dn.tvalid = out_valid;

endmodule

/* hdl/stat_counter_core.sv */
// producer that counts ticks, bytes and frames on a monitored stream and sends a report on trigger
`timescale 1ns/100ps

module stat_counter_core (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [stat_pkg::KEEP_WIDTH-1:0] mon_tkeep,
    input  logic                            mon_tvalid,
    input  logic                            mon_tready,
    input  logic                            mon_tlast,
    input  logic [stat_pkg::TAG_WIDTH-1:0]  tag,
    input  logic                            trigger,
    output logic                            busy,
    stat_report_if.source                   rpt
);

    stat_pkg::core_state_e state;

    logic [stat_pkg::PTR_WIDTH-1:0] byte_ptr;
    logic                           busy_reg;

    // running statistics
    logic [stat_pkg::COUNT_WIDTH-1:0] tick_count;
    logic [stat_pkg::COUNT_WIDTH-1:0] byte_count;
    logic [stat_pkg::COUNT_WIDTH-1:0] frame_count;
    logic                             in_frame;

    // values captured on trigger
    logic [stat_pkg::TAG_WIDTH-1:0]   snap_tag;
    logic [stat_pkg::COUNT_WIDTH-1:0] snap_ticks;
    logic [stat_pkg::COUNT_WIDTH-1:0] snap_bytes;
    logic [stat_pkg::COUNT_WIDTH-1:0] snap_frames;
    logic [8*stat_pkg::REPORT_LEN-1:0] snap_vec;

    logic                             beat;
    logic                             frame_start;
    logic                             accept_trigger;
    logic [stat_pkg::COUNT_WIDTH-1:0] byte_inc;
    logic [stat_pkg::COUNT_WIDTH-1:0] frame_inc;

    // tkeep is low-aligned, so the ones count is the byte count
    function automatic logic [stat_pkg::COUNT_WIDTH-1:0] keep_ones(
        input logic [stat_pkg::KEEP_WIDTH-1:0] keep
    );
        logic [stat_pkg::COUNT_WIDTH-1:0] n;
        n = '0;
        for (int i = 0; i < stat_pkg::KEEP_WIDTH; i++) begin
            n = n + stat_pkg::COUNT_WIDTH'(keep[i]);
        end
        return n;
    endfunction

    assign beat = mon_tvalid && mon_tready;
    // a one-beat frame never sets the flag and is not counted
    assign frame_start = beat && !mon_tlast && !in_frame;
    assign accept_trigger = trigger && (state == stat_pkg::IDLE);

    always_comb begin
        byte_inc = beat ? keep_ones(mon_tkeep) : '0;
        frame_inc = stat_pkg::COUNT_WIDTH'(frame_start);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tick_count <= '0;
            byte_count <= '0;
            frame_count <= '0;
            in_frame <= 1'b0;
        end else begin
            if (accept_trigger) begin
                // this edge's activity goes into the next report
                tick_count <= stat_pkg::COUNT_WIDTH'(stat_pkg::KEEP_WIDTH);
                byte_count <= byte_inc;
                frame_count <= frame_inc;
            end else begin
                tick_count <= tick_count + stat_pkg::COUNT_WIDTH'(stat_pkg::KEEP_WIDTH);
                byte_count <= byte_count + byte_inc;
                frame_count <= frame_count + frame_inc;
            end
            if (beat && mon_tlast) begin
                in_frame <= 1'b0;
            end else if (frame_start) begin
                in_frame <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept_trigger) begin
            snap_tag <= tag;
            snap_ticks <= tick_count;
            snap_bytes <= byte_count;
            snap_frames <= frame_count;
        end
    end

    // report FSM whose pointer moves only on a transfer
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stat_pkg::IDLE;
            byte_ptr <= '0;
            busy_reg <= 1'b0;
        end else begin
            busy_reg <= (state == stat_pkg::SEND);
            case (state)
                stat_pkg::IDLE: begin
                    byte_ptr <= '0;
                    if (trigger) begin
                        state <= stat_pkg::SEND;
                    end
                end
                stat_pkg::SEND: begin
                    if (rpt.tready) begin
                        if (rpt.tlast) begin
                            state <= stat_pkg::IDLE;
                            byte_ptr <= '0;
                        end else begin
                            byte_ptr <= byte_ptr + 1'b1;
                        end
                    end
                end
                default: state <= stat_pkg::IDLE;
            endcase
        end
    end

    // fields go out most significant byte first
    assign snap_vec = {snap_tag, snap_ticks, snap_bytes, snap_frames};

    assign rpt.tdata = snap_vec[8*(stat_pkg::REPORT_LEN - 1 - int'(byte_ptr)) +: 8];
    assign rpt.tvalid = (state == stat_pkg::SEND);
    assign rpt.tlast = (state == stat_pkg::SEND) &&
                       (int'(byte_ptr) == stat_pkg::REPORT_LEN - 1);
    assign busy = busy_reg;

endmodule

/* hdl/stat_monitor_top.sv */
// stream statistics monitor top level: producer, skid buffer and checksum appender on plain ports
`timescale 1ns/100ps

module stat_monitor_top (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [stat_pkg::KEEP_WIDTH-1:0] mon_tkeep,
    input  logic                            mon_tvalid,
    input  logic                            mon_tready,
    input  logic                            mon_tlast,
    input  logic [stat_pkg::TAG_WIDTH-1:0]  tag,
    input  logic                            trigger,
    output logic                            busy,
    output logic [7:0]                      rpt_tdata,
    output logic                            rpt_tvalid,
    output logic                            rpt_tlast,
    input  logic                            rpt_tready
);

    stat_report_if core_to_buf ();
    stat_report_if buf_to_app ();
    // appender output, mapped onto the report ports
    stat_report_if app_out ();

    stat_counter_core u_core (
        .clk        (clk),
        .rst        (rst),
        .mon_tkeep  (mon_tkeep),
        .mon_tvalid (mon_tvalid),
        .mon_tready (mon_tready),
        .mon_tlast  (mon_tlast),
        .tag        (tag),
        .trigger    (trigger),
        .busy       (busy),
        .rpt        (core_to_buf.source)
    );

    report_skid_buffer u_skid (
        .clk (clk),
        .rst (rst),
        .up  (core_to_buf.sink),
        .dn  (buf_to_app.source)
    );

    report_checksum_appender u_app (
        .clk (clk),
        .rst (rst),
        .up  (buf_to_app.sink),
        .dn  (app_out.source)
    );

    assign rpt_tdata = app_out.tdata;
    assign rpt_tvalid = app_out.tvalid;
    assign rpt_tlast = app_out.tlast;
    assign app_out.tready = rpt_tready;

endmodule

/* hdl/stat_pkg.sv */
// shared widths, report length and FSM state types for the stream statistics monitor
package stat_pkg;

    // byte lanes of the monitored 32-bit stream
    localparam int KEEP_WIDTH = 4;

    localparam int TAG_WIDTH = 16;
    localparam int COUNT_WIDTH = 32;

    // tag plus three counters, checksum not included
    localparam int REPORT_LEN = (TAG_WIDTH + 3 * COUNT_WIDTH) / 8;

    // report byte pointer in the producer
    localparam int PTR_WIDTH = 4;

    // producer: waiting for trigger, or serializing the snapshot
    typedef enum logic [0:0] {
        IDLE = 1'b0,
        SEND = 1'b1
    } core_state_e;

    // consumer: forwarding report bytes, or emitting the checksum
    typedef enum logic [0:0] {
        PASS     = 1'b0,
        CHECKSUM = 1'b1
    } app_state_e;

endpackage

/* hdl/stat_report_if.sv */
// byte-wide valid/ready report stream with a last flag, used between the monitor stages
`timescale 1ns/100ps

interface stat_report_if;

    logic [7:0] tdata;
    logic       tvalid;
    logic       tready;
    // marks the final byte of a report
    logic       tlast;

    // a byte moves on a rising edge with tvalid and tready both high
    modport source (
        output tdata,
        output tvalid,
        output tlast,
        input  tready
    );

    modport sink (
        input  tdata,
        input  tvalid,
        input  tlast,
        output tready
    );

endinterface

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the stream statistics monitor testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_stat_monitor -f src.f -Mdir obj_dir

./obj_dir/Vtb_stat_monitor 2>&1 | tee sim.log

# a run that stops early never reaches the pass line
if grep -q "STATUS: FAIL" sim.log || ! grep -q "STATUS: PASS" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation passed"

/* src.f */
hdl/stat_pkg.sv
hdl/stat_report_if.sv
hdl/stat_counter_core.sv
hdl/report_skid_buffer.sv
hdl/report_checksum_appender.sv
hdl/stat_monitor_top.sv
test/stat_monitor_assert.sv
test/tb_stat_monitor.sv

/* test/stat_monitor_assert.sv */
// report stream protocol assertions, bound to the monitor top level in simulation
`timescale 1ns/100ps

module stat_monitor_assert (
    input logic       clk,
    input logic       rst,
    input logic       busy,
    input logic [7:0] rpt_tdata,
    input logic       rpt_tvalid,
    input logic       rpt_tlast,
    input logic       rpt_tready
);

    // a stalled report byte keeps its data and end mark
    property stalled_byte_holds;
        @(posedge clk) disable iff (rst)
            rpt_tvalid && !rpt_tready |=>
                rpt_tvalid && $stable(rpt_tdata) && $stable(rpt_tlast);
    endproperty

    property quiet_after_reset;
        @(posedge clk) rst |=> !busy && !rpt_tvalid;
    endproperty

    assert property (stalled_byte_holds)
        else $error("report byte or end mark changed while stalled");

    assert property (quiet_after_reset)
        else $error("busy or rpt_tvalid high in the cycle after reset");

endmodule

bind stat_monitor_top stat_monitor_assert u_assert (
    .clk        (clk),
    .rst        (rst),
    .busy       (busy),
    .rpt_tdata  (rpt_tdata),
    .rpt_tvalid (rpt_tvalid),
    .rpt_tlast  (rpt_tlast),
    .rpt_tready (rpt_tready)
);

/* test/tb_stat_monitor.sv */
// directed testbench for the stream statistics monitor, used as the simulation top
`timescale 1ns/100ps

module tb_stat_monitor;

    localparam int RX_TIMEOUT = 200;
    localparam int BUSY_TIMEOUT = 100;

    logic                            clk;
    logic                            rst;
    logic [stat_pkg::KEEP_WIDTH-1:0] mon_tkeep;
    logic                            mon_tvalid;
    logic                            mon_tready;
    logic                            mon_tlast;
    logic [stat_pkg::TAG_WIDTH-1:0]  tag;
    logic                            trigger;
    logic                            busy;
    logic [7:0]                      rpt_tdata;
    logic                            rpt_tvalid;
    logic                            rpt_tlast;
    logic                            rpt_tready;

    logic [31:0] rng_state;

    // reference model of the statistics
    logic [31:0] m_edges;
    logic [31:0] m_bytes;
    logic [31:0] m_frames;
    logic        m_in_frame;
    logic        m_report_open;
    logic [15:0] exp_tag;
    logic [31:0] exp_ticks;
    logic [31:0] exp_bytes;
    logic [31:0] exp_frames;

    // fields of the last received report
    logic [15:0] rx_tag;
    logic [31:0] rx_ticks;
    logic [31:0] rx_bytes;
    logic [31:0] rx_frames;

    stat_monitor_top DUT (
        .clk        (clk),
        .rst        (rst),
        .mon_tkeep  (mon_tkeep),
        .mon_tvalid (mon_tvalid),
        .mon_tready (mon_tready),
        .mon_tlast  (mon_tlast),
        .tag        (tag),
        .trigger    (trigger),
        .busy       (busy),
        .rpt_tdata  (rpt_tdata),
        .rpt_tvalid (rpt_tvalid),
        .rpt_tlast  (rpt_tlast),
        .rpt_tready (rpt_tready)
    );

    always #50 clk = ~clk;

    // inputs change 10 ns after the edge, so the model sees settled values here
    always @(posedge clk) begin
        if (rst) begin
            m_edges = '0;
            m_bytes = '0;
            m_frames = '0;
            m_in_frame = 1'b0;
            m_report_open = 1'b0;
        end else begin
            if (trigger && !m_report_open) begin
                exp_tag = tag;
                exp_ticks = 32'(stat_pkg::KEEP_WIDTH) * m_edges;
                exp_bytes = m_bytes;
                exp_frames = m_frames;
                m_edges = '0;
                m_bytes = '0;
                m_frames = '0;
                m_report_open = 1'b1;
            end
            m_edges = m_edges + 1;
            if (mon_tvalid && mon_tready) begin
                m_bytes = m_bytes + 32'($countones(mon_tkeep));
                if (mon_tlast) begin
                    m_in_frame = 1'b0;
                end else if (!m_in_frame) begin
                    m_frames = m_frames + 1;
                    m_in_frame = 1'b1;
                end
            end
        end
    end

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // modulo-256 sum of the four bytes of a word
    function automatic logic [7:0] word_byte_sum(input logic [31:0] w);
        return w[31:24] + w[23:16] + w[15:8] + w[7:0];
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s, got %0h, expected %0h",
                     $time, msg, actual, expected);
            $display("STATUS: FAIL");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("TIMEOUT at %0t: %s within the cycle limit", $time, what);
        $display("STATUS: FAIL");
        $fatal(1, "timeout");
    endtask

    task automatic wait_busy(input logic level);
        int waited;
        waited = 0;
        while (busy !== level) begin
            if (waited >= BUSY_TIMEOUT) begin
                fail_timeout($sformatf("busy did not go to %0b", level));
            end else begin
                next_cycle();
                waited++;
            end
        end
    endtask

    task automatic pulse_trigger(input logic [15:0] new_tag);
        tag = new_tag;
        trigger = 1'b1;
        next_cycle();
        trigger = 1'b0;
    endtask

    // sends one beat and stalls the monitored sink at most three cycles
    task automatic send_beat(input logic last);
        logic [31:0] rnd;
        logic        taken;
        int          n;
        int          tries;
        rnd = lcg_next();
        n = int'(rnd[23:16]) % stat_pkg::KEEP_WIDTH + 1;
        mon_tkeep = stat_pkg::KEEP_WIDTH'((1 << n) - 1);
        mon_tvalid = 1'b1;
        mon_tlast = last;
        taken = 1'b0;
        tries = 0;
        while (!taken) begin
            rnd = lcg_next();
            mon_tready = rnd[27] || (tries >= 3);
            taken = mon_tready;
            next_cycle();
            tries++;
        end
        mon_tvalid = 1'b0;
        mon_tlast = 1'b0;
    endtask

    task automatic send_frames(input int count);
        logic [31:0] rnd;
        int          len;
        for (int f = 0; f < count; f++) begin
            rnd = lcg_next();
            len = int'(rnd[29:28]) + 1;
            for (int b = 0; b < len; b++) begin
                send_beat(b == len - 1);
            end
            // idle gap with ready but no valid
            mon_tready = 1'b1;
            next_cycle();
            mon_tready = 1'b0;
        end
    endtask

    // collects the report plus checksum and checks it against the model
    task automatic receive_report(input logic random_ready);
        logic [7:0]  rx [0:stat_pkg::REPORT_LEN];
        logic [7:0]  sum;
        logic [31:0] rnd;
        int          n;
        int          idle;
        n = 0;
        idle = 0;
        while (n <= stat_pkg::REPORT_LEN) begin
            if (idle >= RX_TIMEOUT) begin
                fail_timeout($sformatf("report byte %0d did not arrive", n));
            end else begin
                rnd = lcg_next();
                rpt_tready = random_ready ? rnd[30] : 1'b1;
                if (rpt_tvalid && rpt_tready) begin
                    rx[n] = rpt_tdata;
                    check_value(32'(rpt_tlast), 32'(n == stat_pkg::REPORT_LEN),
                                $sformatf("tlast on report byte %0d", n));
                    n++;
                    idle = 0;
                end else begin
                    idle++;
                end
                next_cycle();
            end
        end
        rpt_tready = 1'b1;
        m_report_open = 1'b0;
        rx_tag = {rx[0], rx[1]};
        rx_ticks = {rx[2], rx[3], rx[4], rx[5]};
        rx_bytes = {rx[6], rx[7], rx[8], rx[9]};
        rx_frames = {rx[10], rx[11], rx[12], rx[13]};
        // checksum of the expected report bytes
        sum = word_byte_sum(32'(exp_tag)) + word_byte_sum(exp_ticks) +
              word_byte_sum(exp_bytes) + word_byte_sum(exp_frames);
        check_value(32'(rx_tag), 32'(exp_tag), "report tag");
        check_value(rx_ticks, exp_ticks, "tick count");
        check_value(rx_bytes, exp_bytes, "byte count");
        check_value(rx_frames, exp_frames, "frame count");
        check_value(32'(rx[stat_pkg::REPORT_LEN]), 32'(sum), "checksum");
    endtask

    task automatic test_reset_state();
        for (int i = 0; i < 20; i++) begin
            check_value(32'(busy), 32'd0, "busy idle after reset");
            check_value(32'(rpt_tvalid), 32'd0, "rpt_tvalid idle after reset");
            next_cycle();
        end
    endtask

    task automatic test_idle_report();
        pulse_trigger(16'ha5c3);
        receive_report(1'b0);
        check_value(rx_bytes, 32'd0, "idle byte count");
        check_value(rx_frames, 32'd0, "idle frame count");
    endtask

    task automatic test_traffic_counting();
        send_frames(8);
        pulse_trigger(16'h0f1e);
        receive_report(1'b0);
    endtask

    task automatic test_back_pressure();
        send_frames(4);
        pulse_trigger(16'hc0de);
        receive_report(1'b1);
    endtask

    task automatic test_restart_and_busy_trigger();
        // one beat on the trigger cycle belongs to the following report
        mon_tkeep = stat_pkg::KEEP_WIDTH'(7);
        mon_tvalid = 1'b1;
        mon_tready = 1'b1;
        mon_tlast = 1'b0;
        pulse_trigger(16'h1234);
        mon_tvalid = 1'b0;
        mon_tready = 1'b0;
        fork
            receive_report(1'b0);
            begin
                wait_busy(1'b1);
                pulse_trigger(16'hdead);
            end
        join
        wait_busy(1'b0);
        pulse_trigger(16'h5a5a);
        receive_report(1'b0);
        check_value(32'(rx_tag), 32'h5a5a, "tag after ignored trigger");
        check_value(rx_bytes, 32'd3, "bytes of the trigger cycle beat");
        check_value(rx_frames, 32'd1, "frame of the trigger cycle beat");
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        mon_tkeep = '0;
        mon_tvalid = 1'b0;
        mon_tready = 1'b0;
        mon_tlast = 1'b0;
        tag = '0;
        trigger = 1'b0;
        rpt_tready = 1'b1;
        rng_state = 32'h01f1_c434;
        repeat (5) @(posedge clk);
        #10;
        rst = 1'b0;
        test_reset_state();
        test_idle_report();
        test_traffic_counting();
        test_back_pressure();
        test_restart_and_busy_trigger();
        $display("STATUS: PASS");
        $finish;
    end

endmodule
